//--- apu.sv
module apu (
	input logic sys_clk,
	input logic sys_rst_n,
	input apu_pkg::bus_req_t req,
	output apu_pkg::bus_rsp_t rsp,
	output logic irq_n,
	output logic [7:0] out
);

	apu_pkg::reg_wr_t wr0;
	apu_pkg::reg_wr_t wr1;
	apu_pkg::frame_tick_t tick;
	logic en0;
	logic en1;
	logic act0;
	logic act1;
	logic apu_tick;
	logic frame_wr;
	logic frame_mode;
	logic irq_evt;
	logic [3:0] level0;
	logic [3:0] level1;

	apu_ctrl u_ctrl (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .req(req),
		.act0(act0), .act1(act1), .irq_evt(irq_evt),
		.rsp(rsp), .wr0(wr0), .wr1(wr1), .en0(en0), .en1(en1),
		.apu_tick(apu_tick), .frame_wr(frame_wr), .frame_mode(frame_mode),
		.irq_n(irq_n)
	);

	apu_frame_seq u_frame_seq (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .apu_tick(apu_tick),
		.frame_wr(frame_wr), .frame_mode(frame_mode),
		.tick(tick), .irq_evt(irq_evt)
	);

	apu_pulse u_pulse0 (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .apu_tick(apu_tick),
		.wr(wr0), .en(en0), .tick(tick), .act(act0), .level(level0)
	);

	apu_pulse u_pulse1 (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .apu_tick(apu_tick),
		.wr(wr1), .en(en1), .tick(tick), .act(act1), .level(level1)
	);

	apu_mixer u_mixer (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.level0(level0), .level1(level1), .out(out)
	);

endmodule

//--- apu_cfg.svh
`ifndef APU_CFG_SVH
`define APU_CFG_SVH

// bus window of the register map.
`define APU_BASE 16'h4000
`define APU_SIZE 32

// frame step reloads, in apu ticks.
`define APU_FRAME_LOAD0 12'd3727
`define APU_FRAME_LOAD1 12'd3727
`define APU_FRAME_LOAD2 12'd3728
`define APU_FRAME_LOAD3 12'd3728
`define APU_FRAME_LOAD4 12'd3725

// full scale of the pulse mix table.
`define APU_MIX_SCALE 768

`endif

//--- apu_ctrl.sv
`include "apu_cfg.svh"

module apu_ctrl (
	input logic sys_clk,
	input logic sys_rst_n,
	input apu_pkg::bus_req_t req,
	input logic act0,
	input logic act1,
	input logic irq_evt,
	output apu_pkg::bus_rsp_t rsp,
	output apu_pkg::reg_wr_t wr0,
	output apu_pkg::reg_wr_t wr1,
	output logic en0,
	output logic en1,
	output logic apu_tick,
	output logic frame_wr,
	output logic frame_mode,
	output logic irq_n
);

	logic hit;
	apu_pkg::reg_sel_e sel;
	logic ctrl_sel;
	logic stat_wr;
	logic stat_rd;
	logic inhibit;
	logic irq_flag;
	logic rvalid;
	logic [7:0] rdata;

	assign hit = req.valid && ((req.addr & ~16'(`APU_SIZE - 1)) == `APU_BASE);
	assign sel = apu_pkg::reg_sel_e'(req.addr[4:2]);
	assign ctrl_sel = hit && (sel == apu_pkg::SEL_CTRL);
	assign stat_wr = ctrl_sel && req.we && (req.addr[1:0] == 2'd1);
	assign stat_rd = ctrl_sel && !req.we && (req.addr[1:0] == 2'd1);
	assign frame_wr = ctrl_sel && req.we && (req.addr[1:0] == 2'd3);
	assign frame_mode = req.wdata[7];

	assign wr0.wr = hit && req.we && (sel == apu_pkg::SEL_PULSE0);
	assign wr0.idx = req.addr[1:0];
	assign wr0.data = req.wdata;
	assign wr1.wr = hit && req.we && (sel == apu_pkg::SEL_PULSE1);
	assign wr1.idx = req.addr[1:0];
	assign wr1.data = req.wdata;

	// apu clock as an enable on every second cycle.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			apu_tick <= 1'b0;
		else
			apu_tick <= !apu_tick;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			en0 <= 1'b0;
			en1 <= 1'b0;
			inhibit <= 1'b0;
		end else begin
			if (stat_wr) begin
				en0 <= req.wdata[0];
				en1 <= req.wdata[1];
			end
			if (frame_wr)
				inhibit <= req.wdata[6];
		end
	end

	// frame interrupt flag.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			irq_flag <= 1'b0;
		else if (irq_evt && !inhibit)
			irq_flag <= 1'b1;
		else if (stat_rd || inhibit)
			irq_flag <= 1'b0;
	end

	assign irq_n = !irq_flag;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			rvalid <= 1'b0;
		else
			rvalid <= hit && !req.we;
	end

	// only status is readable.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			rdata <= 8'h00;
		else
			rdata <= stat_rd ? {1'b0, irq_flag, 4'b0000, act1, act0} : 8'h00;
	end

	assign rsp.hit = hit;
	assign rsp.rvalid = rvalid;
	assign rsp.rdata = rdata;

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n) !(wr0.wr && wr1.wr))
		else $error("write strobes to both pulse channels");

endmodule

//--- apu_frame_seq.sv
`include "apu_cfg.svh"

module apu_frame_seq (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic apu_tick,
	input logic frame_wr,
	input logic frame_mode,
	output apu_pkg::frame_tick_t tick,
	output logic irq_evt
);

	apu_pkg::frame_state_e state;
	logic [11:0] cnt;
	logic mode;
	logic restart;

	// a frame write waits here for the next apu tick.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			mode <= 1'b0;
			restart <= 1'b0;
		end else if (frame_wr) begin
			mode <= frame_mode;
			restart <= 1'b1;
		end else if (apu_tick)
			restart <= 1'b0;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= apu_pkg::FS_S0;
			cnt <= `APU_FRAME_LOAD0;
			tick <= '0;
			irq_evt <= 1'b0;
		end else begin
			tick <= '0;
			irq_evt <= 1'b0;
			if (apu_tick) begin
				if (restart) begin
					state <= apu_pkg::FS_S0;
					cnt <= `APU_FRAME_LOAD0;
					// 5-step mode clocks the units at once.
					tick.qframe <= mode;
					tick.hframe <= mode;
				end else if (cnt != 12'd0) begin
					cnt <= cnt - 12'd1;
				end else begin
					case (state)
					apu_pkg::FS_S0: begin
						state <= apu_pkg::FS_S1;
						cnt <= `APU_FRAME_LOAD1;
						tick.qframe <= 1'b1;
					end
					apu_pkg::FS_S1: begin
						state <= apu_pkg::FS_S2;
						cnt <= `APU_FRAME_LOAD2;
						tick.qframe <= 1'b1;
						tick.hframe <= 1'b1;
					end
					apu_pkg::FS_S2: begin
						state <= apu_pkg::FS_S3;
						cnt <= `APU_FRAME_LOAD3;
						tick.qframe <= 1'b1;
					end
					apu_pkg::FS_S3: begin
						if (mode) begin
							state <= apu_pkg::FS_S4;
							cnt <= `APU_FRAME_LOAD4;
						end else begin
							state <= apu_pkg::FS_S0;
							cnt <= `APU_FRAME_LOAD0;
							tick.qframe <= 1'b1;
							tick.hframe <= 1'b1;
							irq_evt <= 1'b1;
						end
					end
					apu_pkg::FS_S4: begin
						state <= apu_pkg::FS_S0;
						cnt <= `APU_FRAME_LOAD0;
						tick.qframe <= 1'b1;
						tick.hframe <= 1'b1;
					end
					default: begin
						state <= apu_pkg::FS_S0;
						cnt <= `APU_FRAME_LOAD0;
					end
					endcase
				end
			end
		end
	end

	// state stays within the five steps.
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		state inside {apu_pkg::FS_S0, apu_pkg::FS_S1, apu_pkg::FS_S2,
			apu_pkg::FS_S3, apu_pkg::FS_S4})
		else $error("frame sequencer in illegal state %0d", state);

endmodule

//--- apu_mixer.sv
`include "apu_cfg.svh"

module apu_mixer (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic [3:0] level0,
	input logic [3:0] level1,
	output logic [7:0] out
);

	// scale * 95.52 / (8128 / n + 100), done in integers.
	function automatic logic [30:0][7:0] build_tab();
		logic [30:0][7:0] tab;
		longint num;
		longint den;
		tab[0] = 8'd0;
		for (int n = 1; n < 31; n++) begin
			num = longint'(`APU_MIX_SCALE) * 64'd9552 * longint'(n);
			den = 64'd812800 + 64'd10000 * longint'(n);
			tab[n] = 8'(num / den);
		end
		return tab;
	endfunction

	localparam logic [30:0][7:0] mix_tab = build_tab();

	logic [4:0] sum;

	assign sum = 5'(level0) + 5'(level1);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			out <= 8'd0;
		else
			out <= mix_tab[sum];
	end

endmodule

//--- apu_pkg.sv
package apu_pkg;

	// one bus cycle, accepted in the cycle valid is high.
	typedef struct packed {
		logic valid;
		logic we;
		logic [15:0] addr;
		logic [7:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic hit;
		logic rvalid;
		logic [7:0] rdata;
	} bus_rsp_t;

	// decoded write to one channel.
	typedef struct packed {
		logic wr;
		logic [1:0] idx;
		logic [7:0] data;
	} reg_wr_t;

	// single-cycle frame strobes.
	typedef struct packed {
		logic qframe;
		logic hframe;
	} frame_tick_t;

	// address bits 4 to 2.
	typedef enum logic [2:0] {
		SEL_PULSE0 = 3'd0,
		SEL_PULSE1 = 3'd1,
		SEL_CTRL = 3'd5
	} reg_sel_e;

	typedef enum logic [2:0] {
		FS_S0,
		FS_S1,
		FS_S2,
		FS_S3,
		FS_S4
	} frame_state_e;

endpackage

//--- apu_pulse.sv
module apu_pulse (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic apu_tick,
	input apu_pkg::reg_wr_t wr,
	input logic en,
	input apu_pkg::frame_tick_t tick,
	output logic act,
	output logic [3:0] level
);

	// 12.5%, 25%, 50% and inverted 25% patterns, indexed by step.
	localparam logic [7:0] duty_tab [4] = '{
		8'b0000_0010, 8'b0000_0110, 8'b0001_1110, 8'b1111_1001
	};

	localparam logic [7:0] len_tab [32] = '{
		8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
		8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

	logic [1:0] duty;
	logic halt;
	logic const_vol;
	logic [3:0] vol;
	logic [10:0] period;
	logic [10:0] timer;
	logic [2:0] step;
	logic [7:0] length;
	logic env_start;
	logic [3:0] env_div;
	logic [3:0] env_decay;
	logic wr3;
	logic gate;
	logic [3:0] env_out;

	assign wr3 = wr.wr && (wr.idx == 2'd3);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			duty <= 2'd0;
			halt <= 1'b0;
			const_vol <= 1'b0;
			vol <= 4'd0;
			period <= 11'd0;
		end else if (wr.wr) begin
			case (wr.idx)
			2'd0: begin
				duty <= wr.data[7:6];
				halt <= wr.data[5];
				const_vol <= wr.data[4];
				vol <= wr.data[3:0];
			end
			2'd2: period[7:0] <= wr.data;
			2'd3: period[10:8] <= wr.data[2:0];
			// register 1 is the sweep unit, not present.
			default: ;
			endcase
		end
	end

	// timer and duty step.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			timer <= 11'd0;
			step <= 3'd0;
		end else begin
			if (apu_tick) begin
				if (timer == 11'd0) begin
					timer <= period;
					step <= step + 3'd1;
				end else
					timer <= timer - 11'd1;
			end
			if (wr3)
				step <= 3'd0;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			length <= 8'd0;
		else if (!en)
			length <= 8'd0;
		else if (wr3)
			length <= len_tab[wr.data[7:3]];
		else if (tick.hframe && !halt && length != 8'd0)
			length <= length - 8'd1;
	end

	// envelope, stepped on quarter frames.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			env_start <= 1'b0;
			env_div <= 4'd0;
			env_decay <= 4'd0;
		end else if (wr3) begin
			env_start <= 1'b1;
		end else if (tick.qframe) begin
			if (env_start) begin
				env_start <= 1'b0;
				env_decay <= 4'd15;
				env_div <= vol;
			end else if (env_div == 4'd0) begin
				env_div <= vol;
				if (env_decay != 4'd0)
					env_decay <= env_decay - 4'd1;
				else if (halt)
					env_decay <= 4'd15;
			end else
				env_div <= env_div - 4'd1;
		end
	end

	assign act = (length != 8'd0);
	assign env_out = const_vol ? vol : env_decay;
	// short periods are ultrasonic and muted.
	assign gate = duty_tab[duty][step] && act && (period >= 11'd8);
	assign level = gate ? env_out : 4'd0;

endmodule

//--- flist.f
+incdir+.
apu_pkg.sv
apu_mixer.sv
apu_pulse.sv
apu_frame_seq.sv
apu_ctrl.sv
apu.sv
tb_apu.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run into sim.log, then search the log for failure.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_apu \
	-f flist.f -o tb_apu \
	&& ./obj_dir/tb_apu > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0

//--- tb_apu.sv
`include "apu_cfg.svh"

module tb_apu;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period = 40;
	// one 4-step and one 5-step frame, in sys cycles.
	localparam int frame4_cycles = 2 * (int'(`APU_FRAME_LOAD0) + int'(`APU_FRAME_LOAD1)
		+ int'(`APU_FRAME_LOAD2) + int'(`APU_FRAME_LOAD3) + 4);
	localparam int frame5_cycles = frame4_cycles + 2 * (int'(`APU_FRAME_LOAD4) + 1);
	localparam logic [15:0] stat_addr = `APU_BASE + 16'h15;
	localparam logic [15:0] frame_addr = `APU_BASE + 16'h17;

	logic sys_clk;
	logic sys_rst_n;
	apu_pkg::bus_req_t req;
	apu_pkg::bus_rsp_t rsp;
	logic irq_n;
	logic [7:0] out;
	int checks = 0;
	int errors = 0;

	apu u_dut (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .req(req), .rsp(rsp),
		.irq_n(irq_n), .out(out)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(clk_period / 2) sys_clk = ~sys_clk;
	end

	function automatic logic [15:0] chan_addr(input int ch, input int idx);
		return `APU_BASE + 16'(ch * 4 + idx);
	endfunction

	function automatic logic in_window(input logic [15:0] addr);
		return (addr >= `APU_BASE) && (addr < `APU_BASE + `APU_SIZE);
	endfunction

	// expected mixer output for a sum of the two channel levels.
	function automatic logic [7:0] mix_ref(input int n);
		real v;
		if (n == 0)
			return 8'd0;
		v = real'(`APU_MIX_SCALE) * 95.52 / (8128.0 / real'(n) + 100.0);
		return 8'($rtoi($floor(v)));
	endfunction

	task automatic check_hit(input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: rsp.hit = %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge sys_clk);
		req.valid <= 1'b1;
		req.we <= 1'b1;
		req.addr <= addr;
		req.wdata <= data;
		@(posedge sys_clk);
		check_hit(rsp.hit, in_window(addr));
		@(negedge sys_clk);
		req.valid <= 1'b0;
		req.we <= 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
		int waited;
		@(negedge sys_clk);
		req.valid <= 1'b1;
		req.we <= 1'b0;
		req.addr <= addr;
		req.wdata <= 8'h00;
		@(posedge sys_clk);
		check_hit(rsp.hit, in_window(addr));
		@(negedge sys_clk);
		req.valid <= 1'b0;
		waited = 0;
		while (!rsp.rvalid && waited < 8) begin
			@(negedge sys_clk);
			waited++;
		end
		if (!rsp.rvalid) begin
			errors++;
			$display("read of %04h got no response within 8 cycles at %0t ns", addr, $time);
		end
		data = rsp.rdata;
	endtask

	task automatic check_status(input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: rsp.rdata = %02h, expected %02h", $time, got, exp);
		end
	endtask

	task automatic check_out(input logic [7:0] got, input logic [7:0] exp, input string name);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_irq(input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: irq_n = %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic sample_out(input int cycles, output logic [7:0] hi, output logic [7:0] lo);
		hi = 8'd0;
		lo = 8'hff;
		repeat (cycles) begin
			@(negedge sys_clk);
			if (out > hi)
				hi = out;
			if (out < lo)
				lo = out;
		end
	endtask

	task automatic hold_irq_high(input int cycles);
		logic all_high;
		all_high = 1'b1;
		repeat (cycles) begin
			@(negedge sys_clk);
			all_high &= irq_n;
		end
		check_irq(all_high, 1'b1);
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - errs_before);
	endtask

	initial begin
		logic [7:0] rd;
		logic [7:0] hi;
		logic [7:0] lo;
		int base;
		int v0;
		int v1;
		int period;
		time t0;
		req = '0;
		sys_rst_n = 1'b0;
		void'($urandom(32'h3db1_0728));
		repeat (10) @(negedge sys_clk);
		sys_rst_n = 1'b1;

		base = errors;
		check_out(out, 8'd0, "out");
		check_irq(irq_n, 1'b1);
		// just past the window.
		bus_write(stat_addr + 16'(`APU_SIZE), 8'h03);
		bus_read(stat_addr, rd);
		check_status(rd, 8'h00);
		report_test("1 reset state", base);

		// full volume and 50% duty, so out moves before the enables drop.
		base = errors;
		period = 8;
		bus_write(stat_addr, 8'h03);
		bus_write(chan_addr(0, 0), 8'hbf);
		bus_write(chan_addr(1, 0), 8'hbf);
		bus_write(chan_addr(0, 2), 8'(period));
		bus_write(chan_addr(1, 2), 8'(period));
		bus_write(chan_addr(0, 3), 8'h00);
		bus_write(chan_addr(1, 3), 8'h00);
		bus_read(stat_addr, rd);
		check_status(rd, 8'h03);
		sample_out(2 * 16 * (period + 1), hi, lo);
		check_out(hi, mix_ref(30), "out max");
		bus_write(stat_addr, 8'h00);
		bus_read(stat_addr, rd);
		check_status(rd, 8'h00);
		sample_out(2 * 16 * (period + 1), hi, lo);
		check_out(hi, 8'd0, "out max");
		report_test("2 enables and status", base);

		// inhibit keeps the flag clear through the long waits.
		base = errors;
		bus_write(frame_addr, 8'h40);
		bus_write(stat_addr, 8'h01);
		bus_write(chan_addr(0, 0), 8'h00);
		bus_write(chan_addr(0, 3), 8'h18);
		bus_read(stat_addr, rd);
		check_status(rd, 8'h01);
		t0 = $time;
		while (rd[0] && ($time - t0) < time'(3 * frame4_cycles * clk_period))
			bus_read(stat_addr, rd);
		if (rd[0]) begin
			errors++;
			$display("channel 0 still active after three frame periods at %0t ns", $time);
		end else
			check_status(rd, 8'h00);
		report_test("3 length counter", base);

		// halt set, constant volume, 50% duty.
		base = errors;
		v0 = $urandom_range(15, 0);
		v1 = $urandom_range(15, 0);
		period = $urandom_range(31, 8);
		bus_write(stat_addr, 8'h03);
		bus_write(chan_addr(0, 0), 8'hb0 | 8'(v0));
		bus_write(chan_addr(1, 0), 8'hb0 | 8'(v1));
		bus_write(chan_addr(0, 2), 8'(period));
		bus_write(chan_addr(1, 2), 8'(period));
		bus_write(chan_addr(0, 3), 8'h08);
		bus_write(chan_addr(1, 3), 8'h08);
		repeat (4) @(negedge sys_clk);
		sample_out(8 * 16 * (period + 1), hi, lo);
		check_out(hi, mix_ref(v0 + v1), "out max");
		check_out(lo, 8'd0, "out min");
		report_test("4 mixer output", base);

		base = errors;
		bus_write(stat_addr, 8'h00);
		bus_write(frame_addr, 8'h00);
		t0 = $time;
		while (irq_n && ($time - t0) < time'((frame4_cycles + 64) * clk_period))
			@(negedge sys_clk);
		if (irq_n) begin
			errors++;
			$display("frame interrupt did not arrive within one frame at %0t ns", $time);
		end
		bus_read(stat_addr, rd);
		check_status(rd, 8'h40);
		check_irq(irq_n, 1'b1);
		bus_write(frame_addr, 8'h40);
		hold_irq_high(2 * frame4_cycles);
		bus_write(frame_addr, 8'h80);
		hold_irq_high(2 * frame5_cycles);
		report_test("5 frame interrupt", base);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
